// ==== src/riscv_pkg.sv ====
package riscv_pkg;

  parameter int INST_W     = 32;
  parameter int REG_ADDR_W = 5;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [INST_W-1:0]     inst_t;

  //////////////////////////////
  // major opcodes of the subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,  // reg-reg alu
    OP_IMM = 7'b0010011,  // addi
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,  // full-width load
    STORE  = 7'b0100011,  // full-width store
    BRANCH = 7'b1100011,  // beq and bne
    JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD   = 3'd0,
    ALU_SUB   = 3'd1,
    ALU_AND   = 3'd2,
    ALU_OR    = 3'd3,
    ALU_XOR   = 3'd4,
    ALU_SLT   = 3'd5,
    ALU_PASSB = 3'd6   // operand b straight through, used by lui
  } alu_op_e;

  typedef enum logic [1:0] {
    RES_ALU = 2'd0,
    RES_MEM = 2'd1,
    RES_PC4 = 2'd2   // link value for jal
  } result_src_e;

  typedef enum logic [1:0] {
    FWD_REG = 2'd0,  // value read in decode
    FWD_MEM = 2'd1,
    FWD_WB  = 2'd2
  } fwd_sel_e;

  parameter int unsigned RESET_PC_DEFAULT = 0;

endpackage

// ==== src/riscv_fetch.sv ====
`timescale 1ns/10ps

module riscv_fetch #(
  parameter int              XLEN     = 64,
  parameter logic [XLEN-1:0] RESET_PC = XLEN'(riscv_pkg::RESET_PC_DEFAULT)
) (
  input  logic             i_riscv_fetch_clk,
  input  logic             i_rst_n,
  input  logic             i_stall,
  input  logic             i_flush,
  input  logic             i_redirect,
  input  logic [XLEN-1:0]  i_redirect_pc,
  input  riscv_pkg::inst_t i_inst,
  output logic [XLEN-1:0]  o_pc,
  output logic [XLEN-1:0]  o_pc_d,
  output riscv_pkg::inst_t o_inst_d
);

  logic [XLEN-1:0] pc_next;

  always_comb begin
    if (i_redirect) begin
      pc_next = i_redirect_pc;  // branch or jal from execute
    end else if (i_stall) begin
      pc_next = o_pc;           // load-use hold
    end else begin
      pc_next = o_pc + XLEN'(4);
    end
  end

  always_ff @(posedge i_riscv_fetch_clk) begin
    if (!i_rst_n) begin
      o_pc <= RESET_PC;
    end else begin
      o_pc <= pc_next;
    end
  end

  //////////////////////////////
  // fetch/decode register
  always_ff @(posedge i_riscv_fetch_clk) begin
    if (!i_rst_n || i_flush) begin
      o_inst_d <= '0;  // all-zero word decodes as a bubble
    end else if (!i_stall) begin
      o_inst_d <= i_inst;
    end
  end

  always_ff @(posedge i_riscv_fetch_clk) begin
    if (!i_stall) begin
      o_pc_d <= o_pc;
    end
  end

  a_pc_aligned : assert property (@(posedge i_riscv_fetch_clk) disable iff (!i_rst_n)
    o_pc[1:0] == 2'b00);

endmodule

// ==== src/riscv_regfile.sv ====
`timescale 1ns/10ps

module riscv_regfile #(
  parameter int XLEN = 64
) (
  input  logic                 i_riscv_regfile_clk,
  input  riscv_pkg::reg_addr_t i_rs1,
  input  riscv_pkg::reg_addr_t i_rs2,
  input  logic                 i_we,
  input  riscv_pkg::reg_addr_t i_rd,
  input  logic [XLEN-1:0]      i_wdata,
  output logic [XLEN-1:0]      o_rs1_data,
  output logic [XLEN-1:0]      o_rs2_data
);

  logic [XLEN-1:0] regs [1:31];  // x0 has no storage
  logic            wr_en;

  assign wr_en = i_we && (i_rd != '0);

  always_ff @(posedge i_riscv_regfile_clk) begin
    if (wr_en) begin
      regs[i_rd] <= i_wdata;
    end
  end

  // writeback value bypasses the array in the same cycle
  assign o_rs1_data = (i_rs1 == '0)                 ? '0      :
                      (wr_en && (i_rd == i_rs1))    ? i_wdata : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0)                 ? '0      :
                      (wr_en && (i_rd == i_rs2))    ? i_wdata : regs[i_rs2];

endmodule

// ==== src/riscv_decode.sv ====
`timescale 1ns/10ps

module riscv_decode #(
  parameter int XLEN = 64
) (
  input  logic                   i_riscv_decode_clk,
  input  logic                   i_rst_n,
  input  logic                   i_flush,
  input  riscv_pkg::inst_t       i_inst,
  input  logic [XLEN-1:0]        i_pc,
  input  logic                   i_wb_we,
  input  riscv_pkg::reg_addr_t   i_wb_rd,
  input  logic [XLEN-1:0]        i_wb_data,
  output riscv_pkg::reg_addr_t   o_rs1_d,
  output riscv_pkg::reg_addr_t   o_rs2_d,
  output logic [XLEN-1:0]        o_pc_e,
  output logic [XLEN-1:0]        o_rs1_data_e,
  output logic [XLEN-1:0]        o_rs2_data_e,
  output logic [XLEN-1:0]        o_imm_e,
  output riscv_pkg::reg_addr_t   o_rs1_e,
  output riscv_pkg::reg_addr_t   o_rs2_e,
  output riscv_pkg::reg_addr_t   o_rd_e,
  output riscv_pkg::alu_op_e     o_alu_op_e,
  output logic                   o_use_imm_e,
  output logic                   o_reg_we_e,
  output logic                   o_mem_we_e,
  output logic                   o_mem_re_e,
  output logic                   o_branch_e,
  output logic                   o_branch_ne_e,
  output logic                   o_jump_e,
  output riscv_pkg::result_src_e o_result_src_e
);

  riscv_pkg::opcode_e     opcode;
  riscv_pkg::alu_op_e     alu_op;
  riscv_pkg::result_src_e result_src;
  logic [2:0]             funct3;
  logic [XLEN-1:0]        imm;
  logic [XLEN-1:0]        rs1_data;
  logic [XLEN-1:0]        rs2_data;
  logic                   use_imm;
  logic                   reg_we;
  logic                   mem_we;
  logic                   mem_re;
  logic                   branch;
  logic                   branch_ne;
  logic                   jump;

  assign opcode  = riscv_pkg::opcode_e'(i_inst[6:0]);
  assign funct3  = i_inst[14:12];
  assign o_rs1_d = i_inst[19:15];
  assign o_rs2_d = i_inst[24:20];

  riscv_regfile #(.XLEN(XLEN)) u_riscv_regfile (
    .i_riscv_regfile_clk (i_riscv_decode_clk),
    .i_rs1               (o_rs1_d),
    .i_rs2               (o_rs2_d),
    .i_we                (i_wb_we),
    .i_rd                (i_wb_rd),
    .i_wdata             (i_wb_data),
    .o_rs1_data          (rs1_data),
    .o_rs2_data          (rs2_data)
  );

  //////////////////////////////
  // control and immediate
  always_comb begin
    alu_op     = riscv_pkg::ALU_ADD;
    result_src = riscv_pkg::RES_ALU;
    imm        = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};  // i-type
    use_imm    = 1'b0;
    reg_we     = 1'b0;
    mem_we     = 1'b0;
    mem_re     = 1'b0;
    branch     = 1'b0;
    branch_ne  = 1'b0;
    jump       = 1'b0;
    case (opcode)
      riscv_pkg::OP: begin
        reg_we = 1'b1;
        case (funct3)
          3'b000:  alu_op = i_inst[30] ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
          3'b010:  alu_op = riscv_pkg::ALU_SLT;
          3'b100:  alu_op = riscv_pkg::ALU_XOR;
          3'b110:  alu_op = riscv_pkg::ALU_OR;
          3'b111:  alu_op = riscv_pkg::ALU_AND;
          default: alu_op = riscv_pkg::ALU_ADD;
        endcase
      end
      riscv_pkg::OP_IMM: begin
        reg_we  = 1'b1;  // addi only
        use_imm = 1'b1;
      end
      riscv_pkg::LUI: begin
        reg_we  = 1'b1;
        use_imm = 1'b1;
        alu_op  = riscv_pkg::ALU_PASSB;
        imm     = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
      end
      riscv_pkg::LOAD: begin
        reg_we     = 1'b1;
        use_imm    = 1'b1;
        mem_re     = 1'b1;
        result_src = riscv_pkg::RES_MEM;
      end
      riscv_pkg::STORE: begin
        use_imm = 1'b1;
        mem_we  = 1'b1;
        imm     = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
      end
      riscv_pkg::BRANCH: begin
        branch    = 1'b1;
        branch_ne = funct3[0];  // 000 beq, 001 bne
        imm       = {{(XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                     i_inst[11:8], 1'b0};
      end
      riscv_pkg::JAL: begin
        jump       = 1'b1;
        reg_we     = 1'b1;
        result_src = riscv_pkg::RES_PC4;
        imm        = {{(XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                      i_inst[30:21], 1'b0};
      end
      default: ;  // unknown word stays a bubble
    endcase
  end

  //////////////////////////////
  // decode/execute register
  always_ff @(posedge i_riscv_decode_clk) begin
    if (!i_rst_n || i_flush) begin
      o_rd_e     <= '0;
      o_reg_we_e <= 1'b0;
      o_mem_we_e <= 1'b0;
      o_mem_re_e <= 1'b0;
      o_branch_e <= 1'b0;
      o_jump_e   <= 1'b0;
    end else begin
      o_rd_e     <= i_inst[11:7];
      o_reg_we_e <= reg_we;
      o_mem_we_e <= mem_we;
      o_mem_re_e <= mem_re;
      o_branch_e <= branch;
      o_jump_e   <= jump;
    end
  end

  always_ff @(posedge i_riscv_decode_clk) begin
    o_pc_e         <= i_pc;
    o_rs1_data_e   <= rs1_data;
    o_rs2_data_e   <= rs2_data;
    o_imm_e        <= imm;
    o_rs1_e        <= o_rs1_d;
    o_rs2_e        <= o_rs2_d;
    o_alu_op_e     <= alu_op;
    o_use_imm_e    <= use_imm;
    o_branch_ne_e  <= branch_ne;
    o_result_src_e <= result_src;
  end

endmodule

// ==== src/riscv_execute.sv ====
`timescale 1ns/10ps

module riscv_execute #(
  parameter int XLEN = 64
) (
  input  logic                   i_riscv_execute_clk,
  input  logic                   i_rst_n,
  input  logic [XLEN-1:0]        i_pc,
  input  logic [XLEN-1:0]        i_rs1_data,
  input  logic [XLEN-1:0]        i_rs2_data,
  input  logic [XLEN-1:0]        i_imm,
  input  riscv_pkg::reg_addr_t   i_rd,
  input  riscv_pkg::alu_op_e     i_alu_op,
  input  logic                   i_use_imm,
  input  logic                   i_reg_we,
  input  logic                   i_mem_we,
  input  logic                   i_mem_re,
  input  logic                   i_branch,
  input  logic                   i_branch_ne,
  input  logic                   i_jump,
  input  riscv_pkg::result_src_e i_result_src,
  input  riscv_pkg::fwd_sel_e    i_fwd_a,
  input  riscv_pkg::fwd_sel_e    i_fwd_b,
  input  logic [XLEN-1:0]        i_result_m,
  input  logic [XLEN-1:0]        i_wb_data,
  output logic                   o_redirect,
  output logic [XLEN-1:0]        o_redirect_pc,
  output riscv_pkg::reg_addr_t   o_rd_m,
  output logic                   o_reg_we_m,
  output logic                   o_mem_re_m,
  output logic                   o_mem_we_m,
  output logic [XLEN-1:0]        o_result_m,
  output logic [XLEN-1:0]        o_store_data_m,
  output logic [XLEN-1:0]        o_pc4_m,
  output riscv_pkg::result_src_e o_result_src_m
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] rs2_fwd;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_res;
  logic            taken;

  function automatic logic [XLEN-1:0] fwd_mux(input riscv_pkg::fwd_sel_e sel,
                                              input logic [XLEN-1:0] reg_val,
                                              input logic [XLEN-1:0] mem_val,
                                              input logic [XLEN-1:0] wb_val);
    case (sel)
      riscv_pkg::FWD_MEM: return mem_val;
      riscv_pkg::FWD_WB:  return wb_val;
      default:            return reg_val;
    endcase
  endfunction

  assign op_a    = fwd_mux(i_fwd_a, i_rs1_data, i_result_m, i_wb_data);
  assign rs2_fwd = fwd_mux(i_fwd_b, i_rs2_data, i_result_m, i_wb_data);  // also store data
  assign op_b    = i_use_imm ? i_imm : rs2_fwd;

  always_comb begin
    case (i_alu_op)
      riscv_pkg::ALU_ADD:   alu_res = op_a + op_b;
      riscv_pkg::ALU_SUB:   alu_res = op_a - op_b;
      riscv_pkg::ALU_AND:   alu_res = op_a & op_b;
      riscv_pkg::ALU_OR:    alu_res = op_a | op_b;
      riscv_pkg::ALU_XOR:   alu_res = op_a ^ op_b;
      riscv_pkg::ALU_SLT:   alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      riscv_pkg::ALU_PASSB: alu_res = op_b;
      default:              alu_res = '0;
    endcase
  end

  // bne flips the equality test
  assign taken         = i_branch && ((op_a == rs2_fwd) != i_branch_ne);
  assign o_redirect    = taken || i_jump;
  assign o_redirect_pc = i_pc + i_imm;

  //////////////////////////////
  // execute/memory register
  always_ff @(posedge i_riscv_execute_clk) begin
    if (!i_rst_n) begin
      o_reg_we_m <= 1'b0;
      o_mem_re_m <= 1'b0;
      o_mem_we_m <= 1'b0;
    end else begin
      o_reg_we_m <= i_reg_we;
      o_mem_re_m <= i_mem_re;
      o_mem_we_m <= i_mem_we;
    end
  end

  always_ff @(posedge i_riscv_execute_clk) begin
    o_rd_m         <= i_rd;
    o_result_m     <= alu_res;
    o_store_data_m <= rs2_fwd;
    o_pc4_m        <= i_pc + XLEN'(4);
    o_result_src_m <= i_result_src;
  end

endmodule

// ==== src/riscv_memwb.sv ====
`timescale 1ns/10ps

module riscv_memwb #(
  parameter int XLEN = 64
) (
  input  logic                   i_riscv_memwb_clk,
  input  logic                   i_rst_n,
  input  riscv_pkg::reg_addr_t   i_rd_m,
  input  logic                   i_reg_we_m,
  input  logic                   i_mem_re_m,
  input  logic                   i_mem_we_m,
  input  logic [XLEN-1:0]        i_result_m,
  input  logic [XLEN-1:0]        i_store_data_m,
  input  logic [XLEN-1:0]        i_pc4_m,
  input  riscv_pkg::result_src_e i_result_src_m,
  input  logic [XLEN-1:0]        i_mem_rdata,
  output logic [XLEN-1:0]        o_mem_addr,
  output logic [XLEN-1:0]        o_mem_wdata,
  output logic                   o_mem_we,
  output logic                   o_mem_re,
  output logic                   o_wb_we,
  output riscv_pkg::reg_addr_t   o_wb_rd,
  output logic [XLEN-1:0]        o_wb_data
);

  riscv_pkg::result_src_e result_src_w;
  logic [XLEN-1:0]        result_w;
  logic [XLEN-1:0]        load_w;
  logic [XLEN-1:0]        pc4_w;

  // data port straight from the memory stage, single-cycle strobe
  assign o_mem_addr  = i_result_m;
  assign o_mem_wdata = i_store_data_m;
  assign o_mem_we    = i_mem_we_m;
  assign o_mem_re    = i_mem_re_m;

  always_ff @(posedge i_riscv_memwb_clk) begin
    if (!i_rst_n) begin
      o_wb_we <= 1'b0;
    end else begin
      o_wb_we <= i_reg_we_m;
    end
  end

  always_ff @(posedge i_riscv_memwb_clk) begin
    o_wb_rd      <= i_rd_m;
    result_w     <= i_result_m;
    load_w       <= i_mem_rdata;  // full width, no extension
    pc4_w        <= i_pc4_m;
    result_src_w <= i_result_src_m;
  end

  always_comb begin
    case (result_src_w)
      riscv_pkg::RES_MEM: o_wb_data = load_w;
      riscv_pkg::RES_PC4: o_wb_data = pc4_w;
      default:            o_wb_data = result_w;
    endcase
  end

endmodule

// ==== src/riscv_hazard.sv ====
`timescale 1ns/10ps

module riscv_hazard (
  input  riscv_pkg::reg_addr_t i_rs1_d,
  input  riscv_pkg::reg_addr_t i_rs2_d,
  input  riscv_pkg::reg_addr_t i_rs1_e,
  input  riscv_pkg::reg_addr_t i_rs2_e,
  input  riscv_pkg::reg_addr_t i_rd_e,
  input  riscv_pkg::reg_addr_t i_rd_m,
  input  riscv_pkg::reg_addr_t i_rd_w,
  input  logic                 i_mem_re_e,
  input  logic                 i_reg_we_m,
  input  logic                 i_reg_we_w,
  input  logic                 i_redirect,
  output riscv_pkg::fwd_sel_e  o_fwd_a,
  output riscv_pkg::fwd_sel_e  o_fwd_b,
  output logic                 o_stall,
  output logic                 o_flush_fd,
  output logic                 o_flush_de
);

  // youngest producer wins
  function automatic riscv_pkg::fwd_sel_e fwd_pick(input riscv_pkg::reg_addr_t rs,
                                                   input riscv_pkg::reg_addr_t rd_m,
                                                   input logic                 we_m,
                                                   input riscv_pkg::reg_addr_t rd_w,
                                                   input logic                 we_w);
    if (rs == '0) begin
      return riscv_pkg::FWD_REG;
    end else if (we_m && (rd_m == rs)) begin
      return riscv_pkg::FWD_MEM;
    end else if (we_w && (rd_w == rs)) begin
      return riscv_pkg::FWD_WB;
    end
    return riscv_pkg::FWD_REG;
  endfunction

  assign o_fwd_a = fwd_pick(i_rs1_e, i_rd_m, i_reg_we_m, i_rd_w, i_reg_we_w);
  assign o_fwd_b = fwd_pick(i_rs2_e, i_rd_m, i_reg_we_m, i_rd_w, i_reg_we_w);

  // load in execute feeding the instruction in decode
  assign o_stall    = i_mem_re_e && (i_rd_e != '0) &&
                      ((i_rd_e == i_rs1_d) || (i_rd_e == i_rs2_d));
  assign o_flush_de = o_stall || i_redirect;  // bubble into execute
  assign o_flush_fd = i_redirect;

  always_comb begin
    a_no_stall_on_redirect : assert #0 (!(o_stall && i_redirect));
  end

endmodule

// ==== src/riscv_core.sv ====
`timescale 1ns/10ps

module riscv_core #(
  parameter int              XLEN     = 64,
  parameter logic [XLEN-1:0] RESET_PC = XLEN'(riscv_pkg::RESET_PC_DEFAULT)
) (
  input  logic             i_riscv_core_clk,
  input  logic             i_rst_n,
  input  riscv_pkg::inst_t i_riscv_core_inst,
  output logic [XLEN-1:0]  o_riscv_core_pc,
  input  logic [XLEN-1:0]  i_riscv_core_mem_rdata,
  output logic [XLEN-1:0]  o_riscv_core_mem_addr,
  output logic [XLEN-1:0]  o_riscv_core_mem_wdata,
  output logic             o_riscv_core_mem_we,
  output logic             o_riscv_core_mem_re
);

  //////////////////////////////
  // fetch and decode
  riscv_pkg::inst_t       inst_d;
  logic [XLEN-1:0]        pc_d;
  riscv_pkg::reg_addr_t   rs1_d;
  riscv_pkg::reg_addr_t   rs2_d;
  logic                   stall;
  logic                   flush_fd;
  logic                   flush_de;
  //////////////////////////////
  // execute
  logic [XLEN-1:0]        pc_e;
  logic [XLEN-1:0]        rs1_data_e;
  logic [XLEN-1:0]        rs2_data_e;
  logic [XLEN-1:0]        imm_e;
  riscv_pkg::reg_addr_t   rs1_e;
  riscv_pkg::reg_addr_t   rs2_e;
  riscv_pkg::reg_addr_t   rd_e;
  riscv_pkg::alu_op_e     alu_op_e;
  riscv_pkg::result_src_e result_src_e;
  riscv_pkg::fwd_sel_e    fwd_a;
  riscv_pkg::fwd_sel_e    fwd_b;
  logic                   use_imm_e;
  logic                   reg_we_e;
  logic                   mem_we_e;
  logic                   mem_re_e;
  logic                   branch_e;
  logic                   branch_ne_e;
  logic                   jump_e;
  logic                   redirect;
  logic [XLEN-1:0]        redirect_pc;
  //////////////////////////////
  // memory and writeback
  riscv_pkg::reg_addr_t   rd_m;
  riscv_pkg::result_src_e result_src_m;
  logic                   reg_we_m;
  logic                   mem_re_m;
  logic                   mem_we_m;
  logic [XLEN-1:0]        result_m;
  logic [XLEN-1:0]        store_data_m;
  logic [XLEN-1:0]        pc4_m;
  riscv_pkg::reg_addr_t   wb_rd;
  logic                   wb_we;
  logic [XLEN-1:0]        wb_data;

  riscv_fetch #(.XLEN(XLEN), .RESET_PC(RESET_PC)) u_riscv_fetch (
    .i_riscv_fetch_clk (i_riscv_core_clk),
    .i_rst_n           (i_rst_n),
    .i_stall           (stall),
    .i_flush           (flush_fd),
    .i_redirect        (redirect),
    .i_redirect_pc     (redirect_pc),
    .i_inst            (i_riscv_core_inst),
    .o_pc              (o_riscv_core_pc),
    .o_pc_d            (pc_d),
    .o_inst_d          (inst_d)
  );

  riscv_decode #(.XLEN(XLEN)) u_riscv_decode (
    .i_riscv_decode_clk (i_riscv_core_clk),
    .i_rst_n            (i_rst_n),
    .i_flush            (flush_de),
    .i_inst             (inst_d),
    .i_pc               (pc_d),
    .i_wb_we            (wb_we),
    .i_wb_rd            (wb_rd),
    .i_wb_data          (wb_data),
    .o_rs1_d            (rs1_d),
    .o_rs2_d            (rs2_d),
    .o_pc_e             (pc_e),
    .o_rs1_data_e       (rs1_data_e),
    .o_rs2_data_e       (rs2_data_e),
    .o_imm_e            (imm_e),
    .o_rs1_e            (rs1_e),
    .o_rs2_e            (rs2_e),
    .o_rd_e             (rd_e),
    .o_alu_op_e         (alu_op_e),
    .o_use_imm_e        (use_imm_e),
    .o_reg_we_e         (reg_we_e),
    .o_mem_we_e         (mem_we_e),
    .o_mem_re_e         (mem_re_e),
    .o_branch_e         (branch_e),
    .o_branch_ne_e      (branch_ne_e),
    .o_jump_e           (jump_e),
    .o_result_src_e     (result_src_e)
  );

  riscv_execute #(.XLEN(XLEN)) u_riscv_execute (
    .i_riscv_execute_clk (i_riscv_core_clk),
    .i_rst_n             (i_rst_n),
    .i_pc                (pc_e),
    .i_rs1_data          (rs1_data_e),
    .i_rs2_data          (rs2_data_e),
    .i_imm               (imm_e),
    .i_rd                (rd_e),
    .i_alu_op            (alu_op_e),
    .i_use_imm           (use_imm_e),
    .i_reg_we            (reg_we_e),
    .i_mem_we            (mem_we_e),
    .i_mem_re            (mem_re_e),
    .i_branch            (branch_e),
    .i_branch_ne         (branch_ne_e),
    .i_jump              (jump_e),
    .i_result_src        (result_src_e),
    .i_fwd_a             (fwd_a),
    .i_fwd_b             (fwd_b),
    .i_result_m          (o_riscv_core_mem_addr),  // memory-stage alu result
    .i_wb_data           (wb_data),
    .o_redirect          (redirect),
    .o_redirect_pc       (redirect_pc),
    .o_rd_m              (rd_m),
    .o_reg_we_m          (reg_we_m),
    .o_mem_re_m          (mem_re_m),
    .o_mem_we_m          (mem_we_m),
    .o_result_m          (result_m),
    .o_store_data_m      (store_data_m),
    .o_pc4_m             (pc4_m),
    .o_result_src_m      (result_src_m)
  );

  riscv_memwb #(.XLEN(XLEN)) u_riscv_memwb (
    .i_riscv_memwb_clk (i_riscv_core_clk),
    .i_rst_n           (i_rst_n),
    .i_rd_m            (rd_m),
    .i_reg_we_m        (reg_we_m),
    .i_mem_re_m        (mem_re_m),
    .i_mem_we_m        (mem_we_m),
    .i_result_m        (result_m),
    .i_store_data_m    (store_data_m),
    .i_pc4_m           (pc4_m),
    .i_result_src_m    (result_src_m),
    .i_mem_rdata       (i_riscv_core_mem_rdata),
    .o_mem_addr        (o_riscv_core_mem_addr),
    .o_mem_wdata       (o_riscv_core_mem_wdata),
    .o_mem_we          (o_riscv_core_mem_we),
    .o_mem_re          (o_riscv_core_mem_re),
    .o_wb_we           (wb_we),
    .o_wb_rd           (wb_rd),
    .o_wb_data         (wb_data)
  );

  riscv_hazard u_riscv_hazard (
    .i_rs1_d    (rs1_d),
    .i_rs2_d    (rs2_d),
    .i_rs1_e    (rs1_e),
    .i_rs2_e    (rs2_e),
    .i_rd_e     (rd_e),
    .i_rd_m     (rd_m),
    .i_rd_w     (wb_rd),
    .i_mem_re_e (mem_re_e),
    .i_reg_we_m (reg_we_m),
    .i_reg_we_w (wb_we),
    .i_redirect (redirect),
    .o_fwd_a    (fwd_a),
    .o_fwd_b    (fwd_b),
    .o_stall    (stall),
    .o_flush_fd (flush_fd),
    .o_flush_de (flush_de)
  );

endmodule

// ==== testbench/riscv_core_tb.sv ====
`timescale 1ns/10ps

module riscv_core_tb;

  localparam int              XLEN      = 64;
  localparam int              PROG_MAX  = 32;
  localparam int              MEM_WORDS = 64;
  localparam logic [XLEN-1:0] RESET_PC  = XLEN'(riscv_pkg::RESET_PC_DEFAULT);

  logic             clk = 1'b0;
  logic             rst_n;
  riscv_pkg::inst_t inst;
  logic [XLEN-1:0]  pc;
  logic [XLEN-1:0]  mem_rdata;
  logic [XLEN-1:0]  mem_addr;
  logic [XLEN-1:0]  mem_wdata;
  logic             mem_we;
  logic             mem_re;

  riscv_pkg::inst_t prog [PROG_MAX];
  logic [XLEN-1:0]  dmem [MEM_WORDS];
  logic [XLEN-1:0]  exp_addr [$];
  logic [XLEN-1:0]  exp_data [$];
  logic [XLEN-1:0]  exp_load [$];
  int               prog_len  = 0;
  int               first_st  = 0;  // program index of the first store
  int               st_idx    = 0;
  int               ld_idx    = 0;
  int               cycle_cnt = 0;
  int               run_cnt   = 0;  // cycles since reset release
  int               rst_cnt   = 0;
  logic [31:0]      rnd_state;

  always #4 clk = ~clk;

  riscv_core #(.XLEN(XLEN), .RESET_PC(RESET_PC)) UUT (
    .i_riscv_core_clk       (clk),
    .i_rst_n                (rst_n),
    .i_riscv_core_inst      (inst),
    .o_riscv_core_pc        (pc),
    .i_riscv_core_mem_rdata (mem_rdata),
    .o_riscv_core_mem_addr  (mem_addr),
    .o_riscv_core_mem_wdata (mem_wdata),
    .o_riscv_core_mem_we    (mem_we),
    .o_riscv_core_mem_re    (mem_re)
  );

  //////////////////////////////
  // instruction encoders
  function automatic riscv_pkg::inst_t enc_r(input logic [6:0] f7, input riscv_pkg::reg_addr_t rs2,
                                             input riscv_pkg::reg_addr_t rs1, input logic [2:0] f3,
                                             input riscv_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, riscv_pkg::OP};
  endfunction

  function automatic riscv_pkg::inst_t enc_i(input int imm, input riscv_pkg::reg_addr_t rs1,
                                             input logic [2:0] f3, input riscv_pkg::reg_addr_t rd,
                                             input riscv_pkg::opcode_e op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic riscv_pkg::inst_t enc_s(input int imm, input riscv_pkg::reg_addr_t rs2,
                                             input riscv_pkg::reg_addr_t rs1);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], riscv_pkg::STORE};  // sd
  endfunction

  function automatic riscv_pkg::inst_t enc_b(input int imm, input riscv_pkg::reg_addr_t rs2,
                                             input riscv_pkg::reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], riscv_pkg::BRANCH};
  endfunction

  function automatic riscv_pkg::inst_t enc_u(input logic [19:0] imm,
                                             input riscv_pkg::reg_addr_t rd);
    return {imm, rd, riscv_pkg::LUI};
  endfunction

  function automatic riscv_pkg::inst_t enc_j(input int imm, input riscv_pkg::reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, riscv_pkg::JAL};
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // instruction and data ports answer in the same cycle
  always_comb begin
    if (pc < XLEN'(4 * prog_len)) begin
      inst = prog[pc[6:2]];
    end else begin
      inst = enc_i(0, 0, 3'b000, 0, riscv_pkg::OP_IMM);  // nop
    end
  end

  always_comb mem_rdata = dmem[mem_addr[8:3]];

  //////////////////////////////
  // checks
  task automatic stop_run();
    $display("Verification failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic fail_value(input string msg);
    $display("Fail %0d ns: %s", $time, msg);
    stop_run();
  endtask

  task automatic check_store(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data,
                             input logic [XLEN-1:0] want_addr, input logic [XLEN-1:0] want_data);
    if ((addr !== want_addr) || (data !== want_data)) begin
      fail_value($sformatf("store %0d wrote %h to %h, expected %h to %h",
                           st_idx, data, addr, want_data, want_addr));
    end
  endtask

  task automatic check_load(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] want_addr);
    if (addr !== want_addr) begin
      fail_value($sformatf("load %0d read from %h, expected %h", ld_idx, addr, want_addr));
    end
  endtask

  task automatic check_pc(input logic [XLEN-1:0] got, input logic [XLEN-1:0] want);
    if (got !== want) begin
      fail_value($sformatf("pc after reset is %h, expected %h", got, want));
    end
  endtask

  task automatic check_idle(input logic we, input string phase);
    if (we !== 1'b0) begin
      fail_value($sformatf("write strobe is %b %s", we, phase));
    end
  endtask

  //////////////////////////////
  // program and expected stores
  task automatic emit(input riscv_pkg::inst_t word);
    prog[prog_len] = word;
    prog_len       = prog_len + 1;
  endtask

  task automatic expect_store(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic fill_memory();
    logic [31:0] hi;
    rnd_state = 32'he14;
    for (int i = 0; i < MEM_WORDS; i++) begin
      rnd_state = xorshift(rnd_state);
      hi        = rnd_state;
      rnd_state = xorshift(rnd_state);
      dmem[i]   = {hi, rnd_state};
    end
  endtask

  task automatic build_program();
    logic [XLEN-1:0] r [32];  // architectural register values
    int              src [6] = '{9, 8, 7, 6, 5, 3};
    r[1] = 64'd93;
    emit(enc_i(93, 0, 3'b000, 1, riscv_pkg::OP_IMM));
    r[2] = r[1] + 64'(-200);
    emit(enc_i(-200, 1, 3'b000, 2, riscv_pkg::OP_IMM));
    r[3] = r[2] + r[1];
    emit(enc_r(7'h00, 1, 2, 3'b000, 3));
    r[4] = r[3] - r[2];  // equals x1 for the branches
    emit(enc_r(7'h20, 2, 3, 3'b000, 4));
    r[5] = r[4] & r[2];
    emit(enc_r(7'h00, 2, 4, 3'b111, 5));
    r[6] = r[5] | r[3];
    emit(enc_r(7'h00, 3, 5, 3'b110, 6));
    r[7] = r[6] ^ r[2];
    emit(enc_r(7'h00, 2, 6, 3'b100, 7));
    r[8] = ($signed(r[3]) < $signed(r[4])) ? 64'd1 : 64'd0;
    emit(enc_r(7'h00, 4, 3, 3'b010, 8));
    r[9] = 64'($signed(32'hfedcb000));
    emit(enc_u(20'hfedcb, 9));
    first_st = prog_len;
    foreach (src[i]) begin
      emit(enc_s(8 * i, src[i], 0));
      expect_store(XLEN'(8 * i), r[src[i]]);
    end
    r[10] = dmem[32];  // load-use pair
    r[11] = r[10] + r[1];
    emit(enc_i(256, 0, 3'b011, 10, riscv_pkg::LOAD));
    exp_load.push_back(XLEN'(256));
    emit(enc_r(7'h00, 1, 10, 3'b000, 11));
    emit(enc_s(48, 11, 0));
    expect_store(XLEN'(48), r[11]);
    emit(enc_b(8, 1, 4, 3'b000));  // beq taken
    emit(enc_s(56, 2, 0));
    emit(enc_b(8, 1, 4, 3'b001));  // bne not taken
    emit(enc_s(56, 4, 0));
    expect_store(XLEN'(56), r[4]);
    r[12] = XLEN'(4 * prog_len + 4);
    emit(enc_j(12, 12));
    emit(enc_s(64, 1, 0));
    emit(enc_s(64, 2, 0));
    emit(enc_s(64, 12, 0));
    expect_store(XLEN'(64), r[12]);
    emit(enc_i(55, 0, 3'b000, 0, riscv_pkg::OP_IMM));  // write to x0
    emit(enc_s(72, 0, 0));
    expect_store(XLEN'(72), '0);
  endtask

  //////////////////////////////
  // monitor and data memory write
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (!rst_n) begin
      rst_cnt <= rst_cnt + 1;
      if (rst_cnt > 0) begin
        check_idle(mem_we, "during reset");
      end
    end else begin
      run_cnt <= run_cnt + 1;
      if (run_cnt == 0) begin
        check_pc(pc, RESET_PC);
      end
      if (run_cnt < first_st + 3) begin  // first store not yet in memory stage
        check_idle(mem_we, $sformatf("in cycle %0d before the first store", run_cnt));
      end else if (mem_we) begin
        dmem[mem_addr[8:3]] <= mem_wdata;
        st_idx              <= st_idx + 1;
        if (st_idx >= exp_addr.size()) begin
          $display("An unexpected store to address %h appeared after all expected stores",
                   mem_addr);
          stop_run();
        end else begin
          check_store(mem_addr, mem_wdata, exp_addr[st_idx], exp_data[st_idx]);
        end
      end
    end
    if ((rst_n || (rst_cnt > 0)) && (mem_re !== 1'b0)) begin
      ld_idx <= ld_idx + 1;
      if (!rst_n || (ld_idx >= exp_load.size())) begin
        $display("An unexpected read strobe appeared at address %h", mem_addr);
        stop_run();
      end else begin
        check_load(mem_addr, exp_load[ld_idx]);
      end
    end
  end

  initial begin
    rst_n = 1'b0;
    fill_memory();
    build_program();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    while ((st_idx < exp_addr.size()) && (cycle_cnt < 4 * prog_len + 64)) begin
      @(posedge clk);
    end
    if (st_idx != exp_addr.size()) begin
      $display("Timeout: only %0d of %0d expected stores were seen after %0d cycles",
               st_idx, exp_addr.size(), cycle_cnt);
      stop_run();
    end else if (ld_idx != exp_load.size()) begin
      $display("Only %0d of %0d expected loads were seen", ld_idx, exp_load.size());
      stop_run();
    end else begin
      repeat (8) @(posedge clk);  // room for a stray strobe
      $display("Verification passed");
      $finish;
    end
  end

endmodule

// ==== verilog.f ====
src/riscv_pkg.sv
src/riscv_fetch.sv
src/riscv_regfile.sv
src/riscv_decode.sv
src/riscv_execute.sv
src/riscv_memwb.sv
src/riscv_hazard.sv
src/riscv_core.sv
testbench/riscv_core_tb.sv

// ==== Bender.yml ====
package:
  name: riscv_core

sources:
  - src/riscv_pkg.sv
  - src/riscv_fetch.sv
  - src/riscv_regfile.sv
  - src/riscv_decode.sv
  - src/riscv_execute.sv
  - src/riscv_memwb.sv
  - src/riscv_hazard.sv
  - src/riscv_core.sv
  - target: test
    files:
      - testbench/riscv_core_tb.sv
